// File: design/rpRegPkg.sv
// Register map, word layouts and disk geometry shared by the RP drive blocks
package rpRegPkg;

   ////////////////////////////////////////
   // Register map
   ////////////////////////////////////////

   // Register select from the host port
   typedef logic [2:0] regAddr_t;

   localparam regAddr_t addrCs1 = 3'd0;
   localparam regAddr_t addrDs  = 3'd1;
   localparam regAddr_t addrEr1 = 3'd2;
   localparam regAddr_t addrDa  = 3'd3;
   localparam regAddr_t addrDc  = 3'd4;
   localparam regAddr_t addrEr2 = 3'd5;
   localparam regAddr_t addrEr3 = 3'd6;
   // Maintenance register, reads as zero
   localparam regAddr_t addrMr  = 3'd7;

   ////////////////////////////////////////
   // Written word layouts
   ////////////////////////////////////////

   // Control word, function and go
   typedef struct packed {
      logic [9:0] unused;
      logic [4:0] func;
      logic       go;
   } cs1Word_t;

   // Desired address word, track and sector
   typedef struct packed {
      logic [2:0] unusedHi;
      logic [4:0] track;
      logic [2:0] unusedLo;
      logic [4:0] sector;
   } daWord_t;

   // One written word seen three ways
   typedef union packed {
      logic [15:0] raw;
      cs1Word_t    cs1;
      daWord_t     da;
   } regWord_u;

   // Host request held stable while req is high
   typedef struct packed {
      logic     write;
      regAddr_t addr;
      regWord_u wdata;
   } hostReq_t;

   // ER1 bits
   localparam int er1Ilf = 0;
   localparam int er1Rmr = 2;
   localparam int er1Iae = 10;
   localparam int er1Wle = 11;

   // DS bits, 5..0 read as zero
   localparam int dsAta = 15;
   localparam int dsErr = 14;
   localparam int dsPip = 13;
   localparam int dsMol = 12;
   localparam int dsWrl = 11;
   localparam int dsLst = 10;
   localparam int dsPgm = 9;
   localparam int dsDpr = 8;
   localparam int dsDry = 7;
   localparam int dsVv  = 6;

   // Geometry, highest valid values
   localparam logic [4:0]  lastSector   = 5'd19;
   localparam logic [4:0]  lastTrack    = 5'd18;
   localparam logic [15:0] lastCylinder = 16'd410;

endpackage

// File: design/rpCtrlPkg.sv
// Function codes, command pulses and mechanics timing used by the RP drive control blocks
package rpCtrlPkg;

   // Supported function codes
   localparam logic [4:0] fnNop    = 5'd0;
   localparam logic [4:0] fnSeek   = 5'd2;
   localparam logic [4:0] fnRecal  = 5'd3;
   localparam logic [4:0] fnDrvClr = 5'd4;
   localparam logic [4:0] fnPreset = 5'd8;
   localparam logic [4:0] fnPakAck = 5'd9;
   localparam logic [4:0] fnSearch = 5'd12;
   localparam logic [4:0] fnWrite  = 5'd24;
   localparam logic [4:0] fnRead   = 5'd28;

   // One-cycle pulses from the decoder
   typedef struct packed {
      logic go;
      logic drvClr;
      logic preset;
      logic pakAck;
      logic seek;
      logic recal;
      logic search;
      logic xferWrite;
      logic xferRead;
   } driveCmd_t;

   // Mechanics timing in clocks
   localparam int seekCycles = 16;
   localparam int xferCycles = 8;
   localparam int cntWidth   = $clog2(seekCycles + 1);

endpackage

// File: design/rpHostPort.sv
// Four-phase req/ack register port that performs host reads and writes of the drive registers
module rpHostPort import rpRegPkg::*;
(
   input  logic        clk,
   input  logic        rst,
   input  logic        req,
   input  hostReq_t    request,
   output logic        ack,
   output logic [15:0] rdata,
   output logic        wrStb,
   output hostReq_t    wrReq,
   input  logic [15:0] cs1Rd,
   input  logic [15:0] ds,
   input  logic [15:0] er1,
   input  logic [15:0] da,
   input  logic [15:0] dc,
   input  logic [15:0] er2,
   input  logic [15:0] er3
);

   typedef enum logic [1:0] {stIdle, stAcked, stWaitLow} portState_t;

   portState_t  state;
   logic        accept;
   logic [15:0] rdMux;

   // Access happens on the edge that sees req in idle
   assign accept = (state == stIdle) && req;

   // Read select
   always_comb
   begin
      case (request.addr)
         addrCs1: rdMux = cs1Rd;
         addrDs:  rdMux = ds;
         addrEr1: rdMux = er1;
         addrDa:  rdMux = da;
         addrDc:  rdMux = dc;
         addrEr2: rdMux = er2;
         addrEr3: rdMux = er3;
         addrMr:  rdMux = 16'd0;
         default: rdMux = 16'd0;
      endcase
   end

   ////////////////////////////////////////
   // Handshake FSM
   ////////////////////////////////////////

   always_ff @(posedge clk or posedge rst)
   begin
      if (rst)
      begin
         state <= stIdle;
         ack   <= 1'b0;
         wrStb <= 1'b0;
      end
      else
      begin
         // Strobe lasts one cycle
         wrStb <= accept && request.write;
         case (state)
            stIdle:
               if (req)
                  state <= stAcked;
            stAcked:
            begin
               // Ack one edge after the access
               ack   <= 1'b1;
               state <= stWaitLow;
            end
            stWaitLow:
               if (!req)
               begin
                  ack   <= 1'b0;
                  state <= stIdle;
               end
            default:
               state <= stIdle;
         endcase
      end
   end

   // Request and read data captured at the access edge
   always_ff @(posedge clk)
   begin
      if (accept)
      begin
         wrReq <= request;
         if (!request.write)
            rdata <= rdMux;
      end
   end

endmodule

// File: design/rpCmdDecode.sv
// Turns CS1 writes with go into drive command pulses and flags illegal or refused functions
module rpCmdDecode import rpRegPkg::*, rpCtrlPkg::*;
(
   input  logic        clk,
   input  logic        rst,
   input  logic        wrStb,
   input  hostReq_t    wrReq,
   input  logic        dry,
   output driveCmd_t   cmd,
   output logic        setIlf,
   output logic        setRmr,
   output logic        cmdAta,
   output logic [15:0] cs1Rd
);

   logic       cs1Write;
   logic [4:0] func;
   logic [4:0] lastFunc;
   driveCmd_t  nextCmd;
   logic       nextIlf;
   logic       nextRmr;
   regWord_u   rdWord;

   assign cs1Write = wrStb && (wrReq.addr == addrCs1);
   assign func     = wrReq.wdata.cs1.func;

   // Function decode
   always_comb
   begin
      nextCmd = '0;
      nextIlf = 1'b0;
      nextRmr = 1'b0;
      if (cs1Write && wrReq.wdata.cs1.go)
      begin
         // Drive clear even when busy
         if (func == fnDrvClr)
         begin
            nextCmd.drvClr = 1'b1;
            nextCmd.go     = 1'b1;
         end
         // Busy drive refuses the rest
         else if (!dry)
            nextRmr = 1'b1;
         else
         begin
            nextCmd.go = 1'b1;
            case (func)
               fnNop:    ;
               fnSeek:   nextCmd.seek      = 1'b1;
               fnRecal:  nextCmd.recal     = 1'b1;
               fnPreset: nextCmd.preset    = 1'b1;
               fnPakAck: nextCmd.pakAck    = 1'b1;
               fnSearch: nextCmd.search    = 1'b1;
               fnWrite:  nextCmd.xferWrite = 1'b1;
               fnRead:   nextCmd.xferRead  = 1'b1;
               default:
               begin
                  // Unload, offset, release and the rest
                  nextCmd.go = 1'b0;
                  nextIlf    = 1'b1;
               end
            endcase
         end
      end
   end

   always_ff @(posedge clk or posedge rst)
   begin
      if (rst)
      begin
         cmd      <= '0;
         setIlf   <= 1'b0;
         setRmr   <= 1'b0;
         cmdAta   <= 1'b0;
         lastFunc <= 5'd0;
      end
      else
      begin
         cmd    <= nextCmd;
         setIlf <= nextIlf;
         setRmr <= nextRmr;
         cmdAta <= nextIlf;
         if (cs1Write)
            lastFunc <= func;
      end
   end

   // CS1 readback, go shows a running operation
   always_comb
   begin
      rdWord         = '0;
      rdWord.cs1.func = lastFunc;
      rdWord.cs1.go   = ~dry;
   end

   assign cs1Rd = rdWord.raw;

endmodule

// File: design/rpErrRegs.sv
// Error registers ER1, ER2 and ER3 with their set, host write and clear rules
module rpErrRegs import rpRegPkg::*, rpCtrlPkg::*;
(
   input  logic        clk,
   input  logic        rst,
   input  logic        clr,
   input  driveCmd_t   cmd,
   input  logic        wrStb,
   input  hostReq_t    wrReq,
   input  logic        setIlf,
   input  logic        setRmr,
   input  logic        setIae,
   input  logic        setWle,
   output logic [15:0] er1,
   output logic [15:0] er2,
   output logic [15:0] er3
);

   logic        clrAll;
   logic [15:0] er1Set;

   // Controller clear or drive clear
   assign clrAll = clr | cmd.drvClr;

   // Error pulses as an ER1 mask
   always_comb
   begin
      er1Set         = '0;
      er1Set[er1Ilf] = setIlf;
      er1Set[er1Rmr] = setRmr;
      er1Set[er1Iae] = setIae;
      er1Set[er1Wle] = setWle;
   end

   always_ff @(posedge clk or posedge rst)
   begin
      if (rst)
      begin
         er1 <= '0;
         er2 <= '0;
         er3 <= '0;
      end
      // Clearing beats any set
      else if (clrAll)
      begin
         er1 <= '0;
         er2 <= '0;
         er3 <= '0;
      end
      else
      begin
         // Host load, then new errors on top
         if (wrStb && (wrReq.addr == addrEr1))
            er1 <= wrReq.wdata.raw | er1Set;
         else
            er1 <= er1 | er1Set;
         // Maintenance registers
         if (wrStb && (wrReq.addr == addrEr2))
            er2 <= wrReq.wdata.raw;
         if (wrStb && (wrReq.addr == addrEr3))
            er3 <= wrReq.wdata.raw;
      end
   end

endmodule

// File: design/rpStatus.sv
// Drive status word DS with attention, last-sector, volume-valid and media change tracking
module rpStatus import rpRegPkg::*, rpCtrlPkg::*;
(
   input  logic        clk,
   input  logic        rst,
   input  logic        clr,
   input  driveCmd_t   cmd,
   input  logic        clrAta,
   input  logic        setAta,
   input  logic        setLst,
   input  logic        daWrite,
   input  logic        cardDetect,
   input  logic        writeProtect,
   input  logic        drivePresent,
   input  logic        pip,
   input  logic        dry,
   input  logic [15:0] er1,
   input  logic [15:0] er2,
   input  logic [15:0] er3,
   output logic [15:0] ds
);

   logic lastCd;
   logic cdValid;
   logic mediaChange;
   logic cardInsert;
   logic errAny;
   logic ata;
   logic lst;
   logic vv;

   ////////////////////////////////////////
   // Media change
   ////////////////////////////////////////

   // Previous card state
   // First cycle after reset only primes it
   always_ff @(posedge clk or posedge rst)
   begin
      if (rst)
      begin
         lastCd  <= 1'b0;
         cdValid <= 1'b0;
      end
      else
      begin
         lastCd  <= cardDetect;
         cdValid <= 1'b1;
      end
   end

   assign mediaChange = cdValid && (cardDetect != lastCd);
   assign cardInsert  = mediaChange && cardDetect;

   // Composite error
   assign errAny = (er1 != '0) | (er2 != '0) | (er3 != '0);

   ////////////////////////////////////////
   // Status flags
   ////////////////////////////////////////

   always_ff @(posedge clk or posedge rst)
   begin
      if (rst)
      begin
         ata <= 1'b0;
         lst <= 1'b0;
         vv  <= 1'b0;
      end
      else
      begin
         // Attention, clear wins
         if (clr | clrAta | cmd.drvClr)
            ata <= 1'b0;
         else if (setAta | mediaChange | (cmd.go & errAny))
            ata <= 1'b1;
         // Last sector transferred
         if (clr | daWrite)
            lst <= 1'b0;
         else if (setLst)
            lst <= 1'b1;
         // New pack needs a fresh pack acknowledge
         if (cardInsert)
            vv <= 1'b0;
         else if (cmd.preset | cmd.pakAck)
            vv <= 1'b1;
      end
   end

   // DS word
   always_comb
   begin
      ds        = '0;
      ds[dsAta] = ata;
      ds[dsErr] = errAny;
      ds[dsPip] = pip;
      ds[dsMol] = cardDetect;
      ds[dsWrl] = writeProtect;
      ds[dsLst] = lst;
      // Not a dual-port drive
      ds[dsPgm] = 1'b0;
      ds[dsDpr] = drivePresent;
      ds[dsDry] = dry;
      ds[dsVv]  = vv;
   end

endmodule

// File: design/rpMechanics.sv
// Desired-address registers and the timing model for positioning and sector transfers
module rpMechanics import rpRegPkg::*, rpCtrlPkg::*;
(
   input  logic        clk,
   input  logic        rst,
   input  logic        clr,
   input  driveCmd_t   cmd,
   input  logic        wrStb,
   input  hostReq_t    wrReq,
   input  logic        writeProtect,
   output logic        pip,
   output logic        dry,
   output logic        setLst,
   output logic        setAta,
   output logic        setIae,
   output logic        setWle,
   output logic [15:0] da,
   output logic [15:0] dc
);

   regWord_u            daReg;
   logic [15:0]         dcReg;
   logic [cntWidth-1:0] cnt;
   logic                posn;
   logic                busy;
   logic                xferEnd;
   logic                atLast;
   logic                addrBad;
   logic                posStart;
   logic                xferStart;

   // Address check against geometry
   assign addrBad = (daReg.da.sector > lastSector) | (daReg.da.track > lastTrack) |
                    (dcReg > lastCylinder);

   // Command acceptance
   assign setIae    = (cmd.seek | cmd.search | cmd.xferRead | cmd.xferWrite) & addrBad;
   assign setWle    = cmd.xferWrite & writeProtect & ~addrBad;
   assign posStart  = ((cmd.seek | cmd.search) & ~addrBad) | cmd.recal;
   assign xferStart = (cmd.xferRead | (cmd.xferWrite & ~writeProtect)) & ~addrBad;

   // Counter state
   assign busy    = (cnt != '0);
   assign xferEnd = (cnt == cntWidth'(1)) & ~posn;
   assign atLast  = (daReg.da.sector == lastSector);

   assign pip    = busy & posn;
   assign dry    = ~busy;
   assign setLst = xferEnd & atLast;
   // Positioning done or command rejected
   assign setAta = setIae | setWle | ((cnt == cntWidth'(1)) & posn);

   ////////////////////////////////////////
   // Operation timer
   ////////////////////////////////////////

   always_ff @(posedge clk or posedge rst)
   begin
      if (rst)
      begin
         cnt  <= '0;
         posn <= 1'b0;
      end
      else if (clr)
         cnt <= '0;
      else if (posStart)
      begin
         cnt  <= cntWidth'(seekCycles);
         posn <= 1'b1;
      end
      else if (xferStart)
      begin
         cnt  <= cntWidth'(xferCycles);
         posn <= 1'b0;
      end
      else if (busy)
         cnt <= cnt - 1'b1;
   end

   // DA and DC registers
   always_ff @(posedge clk or posedge rst)
   begin
      if (rst)
      begin
         daReg <= '0;
         dcReg <= '0;
      end
      else if (clr | cmd.preset)
      begin
         daReg <= '0;
         dcReg <= '0;
      end
      else
      begin
         if (wrStb && (wrReq.addr == addrDa))
            daReg <= wrReq.wdata;
         // Sector advance after a transfer
         else if (xferEnd)
         begin
            if (atLast)
            begin
               daReg.da.sector <= 5'd0;
               daReg.da.track  <= daReg.da.track + 5'd1;
            end
            else
               daReg.da.sector <= daReg.da.sector + 5'd1;
         end
         // Recal returns to cylinder zero
         if (cmd.recal)
            dcReg <= '0;
         else if (wrStb && (wrReq.addr == addrDc))
            dcReg <= wrReq.wdata.raw;
      end
   end

   assign da = daReg.raw;
   assign dc = dcReg;

endmodule

// File: design/rpDrive.sv
// Top of one emulated RP drive, joining the register port, decoder, errors, status and mechanics
module rpDrive import rpRegPkg::*, rpCtrlPkg::*;
(
   input  logic        clk,
   input  logic        rst,
   input  logic        clr,
   input  logic        req,
   input  hostReq_t    request,
   output logic        ack,
   output logic [15:0] rdata,
   input  logic        cardDetect,
   input  logic        writeProtect,
   input  logic        drivePresent
);

   logic        wrStb;
   hostReq_t    wrReq;
   driveCmd_t   cmd;
   logic [15:0] cs1Rd;
   logic [15:0] ds;
   logic [15:0] er1;
   logic [15:0] er2;
   logic [15:0] er3;
   logic [15:0] da;
   logic [15:0] dc;
   logic        setIlf;
   logic        setRmr;
   logic        cmdAta;
   logic        pip;
   logic        dry;
   logic        setLst;
   logic        mechAta;
   logic        setIae;
   logic        setWle;
   logic        clrAta;
   logic        daWrite;
   logic        anyAta;

   // Writing a one to DS bit 15 clears attention
   assign clrAta  = wrStb && (wrReq.addr == addrDs) && wrReq.wdata.raw[dsAta];
   assign daWrite = wrStb && (wrReq.addr == addrDa);
   assign anyAta  = mechAta | cmdAta;

   rpHostPort rpHostPort_i (
      .clk(clk), .rst(rst), .req(req), .request(request), .ack(ack),
      .rdata(rdata), .wrStb(wrStb), .wrReq(wrReq), .cs1Rd(cs1Rd), .ds(ds),
      .er1(er1), .da(da), .dc(dc), .er2(er2), .er3(er3)
   );

   rpCmdDecode rpCmdDecode_i (
      .clk(clk), .rst(rst), .wrStb(wrStb), .wrReq(wrReq), .dry(dry),
      .cmd(cmd), .setIlf(setIlf), .setRmr(setRmr), .cmdAta(cmdAta), .cs1Rd(cs1Rd)
   );

   rpErrRegs rpErrRegs_i (
      .clk(clk), .rst(rst), .clr(clr), .cmd(cmd), .wrStb(wrStb), .wrReq(wrReq),
      .setIlf(setIlf), .setRmr(setRmr), .setIae(setIae), .setWle(setWle),
      .er1(er1), .er2(er2), .er3(er3)
   );

   rpStatus rpStatus_i (
      .clk(clk), .rst(rst), .clr(clr), .cmd(cmd), .clrAta(clrAta),
      .setAta(anyAta), .setLst(setLst), .daWrite(daWrite),
      .cardDetect(cardDetect), .writeProtect(writeProtect),
      .drivePresent(drivePresent), .pip(pip), .dry(dry),
      .er1(er1), .er2(er2), .er3(er3), .ds(ds)
   );

   rpMechanics rpMechanics_i (
      .clk(clk), .rst(rst), .clr(clr), .cmd(cmd), .wrStb(wrStb), .wrReq(wrReq),
      .writeProtect(writeProtect), .pip(pip), .dry(dry), .setLst(setLst),
      .setAta(mechAta), .setIae(setIae), .setWle(setWle), .da(da), .dc(dc)
   );

endmodule

// File: verif/rpDriveTb.sv
// Directed testbench for the RP drive registers, top module rpDriveTb, compiled from filelist.f
module rpDriveTb
   import rpRegPkg::*, rpCtrlPkg::*;
();

   // Port wait limit in clocks
   localparam int portTimeout = 32;
   // DS polls before giving up
   localparam int readyPolls  = 64;

   logic        clk = 1'b0;
   logic        rst;
   logic        clr;
   logic        req;
   hostReq_t    request;
   logic        ack;
   logic [15:0] rdata;
   logic        cardDetect;
   logic        writeProtect;
   logic        drivePresent;

   integer      seed;
   int          checkCount;
   int          errCount;
   int          testCount;
   int          testsFailed;
   int          testErrStart;
   string       testName;
   // Idle DS with a card present
   logic [15:0] baseDs;

   rpDrive rpDrive_i (
      .clk(clk), .rst(rst), .clr(clr), .req(req), .request(request), .ack(ack),
      .rdata(rdata), .cardDetect(cardDetect), .writeProtect(writeProtect),
      .drivePresent(drivePresent)
   );

   always #4 clk = ~clk;

   ////////////////////////////////////////
   // Word builders
   ////////////////////////////////////////

   function automatic logic [15:0] bitOf(input int pos);
      bitOf = 16'd1 << pos;
   endfunction

   // CS1 with go set
   function automatic logic [15:0] cs1Go(input logic [4:0] func);
      cs1Go = {10'd0, func, 1'b1};
   endfunction

   // Track 12..8, sector 4..0
   function automatic logic [15:0] daWord(input logic [4:0] track, input logic [4:0] sector);
      daWord = {3'd0, track, 3'd0, sector};
   endfunction

   ////////////////////////////////////////
   // Bookkeeping
   ////////////////////////////////////////

   task automatic abortRun(input string reason);
      begin
         errCount++;
         $display("ERROR in %s: %s", testName, reason);
         $display("Simulation FAILED");
         $finish;
      end
   endtask

   task automatic checkEq(input string label, input logic [15:0] expected,
                          input logic [15:0] actual);
      begin
         checkCount++;
         if (actual !== expected)
         begin
            errCount++;
            $display("MISMATCH %s (%s): expected %h, actual %h",
                     testName, label, expected, actual);
         end
      end
   endtask

   task automatic startTest(input string name);
      begin
         testName     = name;
         testErrStart = errCount;
         testCount++;
      end
   endtask

   task automatic finishTest();
      begin
         if (errCount == testErrStart)
            $display("Test %s: ok", testName);
         else
         begin
            testsFailed++;
            $display("Test %s: %0d mismatches", testName, errCount - testErrStart);
         end
      end
   endtask

   ////////////////////////////////////////
   // Host bus
   ////////////////////////////////////////

   // One four-phase access with the request held until ack
   task automatic busCycle(input logic isWrite, input regAddr_t addr,
                           input logic [15:0] data, output logic [15:0] readData);
      int waitCnt;
      begin
         @(negedge clk);
         request.write     = isWrite;
         request.addr      = addr;
         request.wdata.raw = data;
         req               = 1'b1;
         waitCnt           = 0;
         while ((ack !== 1'b1) && (waitCnt < portTimeout))
         begin
            @(negedge clk);
            waitCnt++;
         end
         if (ack !== 1'b1)
            abortRun("register port never raised ack");
         else
         begin
            readData = rdata;
            req      = 1'b0;
            waitCnt  = 0;
            // Port idle again before the next request
            while ((ack !== 1'b0) && (waitCnt < portTimeout))
            begin
               @(negedge clk);
               waitCnt++;
            end
            if (ack !== 1'b0)
               abortRun("ack stayed high after req was dropped");
         end
      end
   endtask

   task automatic hostWrite(input regAddr_t addr, input logic [15:0] data);
      logic [15:0] unused;
      begin
         busCycle(1'b1, addr, data, unused);
      end
   endtask

   task automatic hostRead(input regAddr_t addr, output logic [15:0] data);
      begin
         busCycle(1'b0, addr, 16'd0, data);
      end
   endtask

   // Read DS until DRY and return the last word
   task automatic pollReady(output logic [15:0] dsWord);
      int polls;
      begin
         polls = 0;
         hostRead(addrDs, dsWord);
         while (!dsWord[dsDry] && (polls < readyPolls))
         begin
            polls++;
            hostRead(addrDs, dsWord);
         end
         if (!dsWord[dsDry])
            abortRun("drive never became ready");
      end
   endtask

   ////////////////////////////////////////
   // Tests
   ////////////////////////////////////////

   task automatic regAccessTest();
      logic [15:0] rd;
      logic [15:0] er2Val;
      logic [15:0] er3Val;
      begin
         startTest("regAccess");
         // Nonzero so ERR must show
         er2Val = 16'($random(seed)) | 16'h0001;
         er3Val = 16'($random(seed)) | 16'h0100;
         hostRead(addrDs, rd);
         checkEq("ds after reset", baseDs, rd);
         hostRead(addrMr, rd);
         checkEq("mr reads zero", 16'd0, rd);
         hostWrite(addrEr2, er2Val);
         hostWrite(addrEr3, er3Val);
         hostRead(addrEr2, rd);
         checkEq("er2 readback", er2Val, rd);
         hostRead(addrEr3, rd);
         checkEq("er3 readback", er3Val, rd);
         hostRead(addrDs, rd);
         checkEq("ds with err", baseDs | bitOf(dsErr), rd);
         hostWrite(addrCs1, cs1Go(fnDrvClr));
         hostRead(addrEr2, rd);
         checkEq("er2 cleared", 16'd0, rd);
         hostRead(addrEr3, rd);
         checkEq("er3 cleared", 16'd0, rd);
         hostRead(addrDs, rd);
         checkEq("ds after drive clear", baseDs, rd);
         finishTest();
      end
   endtask

   task automatic seekTest();
      logic [15:0] rd;
      logic [4:0]  track;
      logic [4:0]  sector;
      logic [15:0] cyl;
      begin
         startTest("seek");
         track  = 5'($unsigned($random(seed)) % 19);
         sector = 5'($unsigned($random(seed)) % 20);
         cyl    = 16'($unsigned($random(seed)) % 411);
         hostWrite(addrDa, daWord(track, sector));
         hostWrite(addrDc, cyl);
         hostWrite(addrCs1, cs1Go(fnSeek));
         // Positioning in progress
         hostRead(addrDs, rd);
         checkEq("pip and dry in seek", bitOf(dsPip), rd & (bitOf(dsPip) | bitOf(dsDry)));
         // Function code reads back from CS1
         hostRead(addrCs1, rd);
         checkEq("cs1 function", 16'(fnSeek), 16'(rd[5:1]));
         pollReady(rd);
         checkEq("ds after seek", baseDs | bitOf(dsAta), rd);
         hostRead(addrDa, rd);
         checkEq("da kept", daWord(track, sector), rd);
         hostRead(addrDc, rd);
         checkEq("dc kept", cyl, rd);
         hostWrite(addrDs, bitOf(dsAta));
         hostRead(addrDs, rd);
         checkEq("ata cleared", baseDs, rd);
         finishTest();
      end
   endtask

   task automatic badFunctionTest();
      logic [15:0] rd;
      begin
         startTest("badFunction");
         // Code 5 is not supported
         hostWrite(addrCs1, cs1Go(5'd5));
         hostRead(addrEr1, rd);
         checkEq("er1 ilf", bitOf(er1Ilf), rd);
         hostRead(addrDs, rd);
         checkEq("ds ilf", baseDs | bitOf(dsErr) | bitOf(dsAta), rd);
         hostWrite(addrCs1, cs1Go(fnDrvClr));
         // Seek while a read transfer runs
         hostWrite(addrDa, daWord(5'd2, 5'd5));
         hostWrite(addrCs1, cs1Go(fnRead));
         hostWrite(addrCs1, cs1Go(fnSeek));
         hostRead(addrEr1, rd);
         checkEq("er1 rmr", bitOf(er1Rmr), rd);
         pollReady(rd);
         checkEq("ds after refusal", baseDs | bitOf(dsErr), rd);
         hostRead(addrDa, rd);
         checkEq("read still advanced", daWord(5'd2, 5'd6), rd);
         hostWrite(addrCs1, cs1Go(fnDrvClr));
         hostRead(addrDs, rd);
         checkEq("ds after drive clear", baseDs, rd);
         finishTest();
      end
   endtask

   task automatic addrCheckTest();
      logic [15:0] rd;
      logic [15:0] daVal;
      begin
         startTest("addrCheck");
         // Sector 20..31 is past the last one
         daVal = daWord(5'($unsigned($random(seed)) % 19),
                        5'(20 + $unsigned($random(seed)) % 12));
         hostWrite(addrDa, daVal);
         hostWrite(addrCs1, cs1Go(fnSeek));
         hostRead(addrEr1, rd);
         checkEq("er1 iae", bitOf(er1Iae), rd);
         hostRead(addrDs, rd);
         checkEq("ds iae", baseDs | bitOf(dsErr) | bitOf(dsAta), rd);
         hostRead(addrDa, rd);
         checkEq("da after iae", daVal, rd);
         hostWrite(addrCs1, cs1Go(fnDrvClr));
         // Write command on a protected card
         @(negedge clk);
         writeProtect = 1'b1;
         daVal = daWord(5'($unsigned($random(seed)) % 19), 5'($unsigned($random(seed)) % 20));
         hostWrite(addrDa, daVal);
         hostWrite(addrCs1, cs1Go(fnWrite));
         hostRead(addrEr1, rd);
         checkEq("er1 wle", bitOf(er1Wle), rd);
         hostRead(addrDs, rd);
         checkEq("ds wle", baseDs | bitOf(dsWrl) | bitOf(dsErr) | bitOf(dsAta), rd);
         hostRead(addrDa, rd);
         checkEq("da after wle", daVal, rd);
         hostWrite(addrCs1, cs1Go(fnDrvClr));
         @(negedge clk);
         writeProtect = 1'b0;
         hostRead(addrDs, rd);
         checkEq("ds after drive clear", baseDs, rd);
         finishTest();
      end
   endtask

   task automatic transferTest();
      logic [15:0] rd;
      begin
         startTest("transfer");
         // Last sector wraps to the next track
         hostWrite(addrDa, daWord(5'd3, 5'd19));
         hostWrite(addrCs1, cs1Go(fnRead));
         pollReady(rd);
         checkEq("ds lst", baseDs | bitOf(dsLst), rd);
         hostRead(addrDa, rd);
         checkEq("da wrapped", daWord(5'd4, 5'd0), rd);
         hostWrite(addrDa, daWord(5'd7, 5'd4));
         hostRead(addrDs, rd);
         checkEq("lst cleared by da", baseDs, rd);
         hostWrite(addrCs1, cs1Go(fnRead));
         pollReady(rd);
         checkEq("ds after read", baseDs, rd);
         hostRead(addrDa, rd);
         checkEq("sector incremented", daWord(5'd7, 5'd5), rd);
         finishTest();
      end
   endtask

   task automatic mediaChangeTest();
      logic [15:0] rd;
      logic [15:0] noCard;
      begin
         startTest("mediaChange");
         noCard = bitOf(dsDpr) | bitOf(dsDry);
         hostWrite(addrCs1, cs1Go(fnPakAck));
         hostRead(addrDs, rd);
         checkEq("vv set", baseDs | bitOf(dsVv), rd);
         // Card pulled
         @(negedge clk);
         cardDetect = 1'b0;
         hostRead(addrDs, rd);
         checkEq("card removed", noCard | bitOf(dsAta) | bitOf(dsVv), rd);
         hostWrite(addrDs, bitOf(dsAta));
         hostRead(addrDs, rd);
         checkEq("ata cleared", noCard | bitOf(dsVv), rd);
         // New card loses VV
         @(negedge clk);
         cardDetect = 1'b1;
         hostRead(addrDs, rd);
         checkEq("card inserted", baseDs | bitOf(dsAta), rd);
         hostWrite(addrDs, bitOf(dsAta));
         hostRead(addrDs, rd);
         checkEq("ds idle again", baseDs, rd);
         finishTest();
      end
   endtask

   ////////////////////////////////////////
   // Main sequence
   ////////////////////////////////////////

   initial
   begin
      seed         = 58;
      rst          = 1'b1;
      clr          = 1'b0;
      req          = 1'b0;
      request      = '0;
      cardDetect   = 1'b1;
      writeProtect = 1'b0;
      drivePresent = 1'b1;
      checkCount   = 0;
      errCount     = 0;
      testCount    = 0;
      testsFailed  = 0;
      testName     = "reset";
      baseDs       = bitOf(dsMol) | bitOf(dsDpr) | bitOf(dsDry);
      repeat (4) @(posedge clk);
      @(negedge clk);
      rst = 1'b0;

      regAccessTest();
      seekTest();
      badFunctionTest();
      addrCheckTest();
      transferTest();
      mediaChangeTest();

      $display("Tests %0d, failing tests %0d, checks %0d, mismatches %0d",
               testCount, testsFailed, checkCount, errCount);
      if (errCount == 0)
         $display("Simulation PASSED");
      else
         $display("Simulation FAILED");
      $finish;
   end

endmodule

// File: filelist.f
design/rpRegPkg.sv
design/rpCtrlPkg.sv
design/rpHostPort.sv
design/rpCmdDecode.sv
design/rpErrRegs.sv
design/rpStatus.sv
design/rpMechanics.sv
design/rpDrive.sv
verif/rpDriveTb.sv

// File: Makefile
# Verilator build and run of the RP drive testbench

SRCS := $(shell cat filelist.f)

obj_dir/VrpDriveTb: filelist.f $(SRCS)
	verilator --binary --timing -Wno-fatal --top-module rpDriveTb -f filelist.f

run: obj_dir/VrpDriveTb
	./obj_dir/VrpDriveTb | tee sim.log
	grep -q "Simulation PASSED" sim.log

clean:
	rm -rf obj_dir sim.log

.PHONY: run clean
